//--- filelist.f
hdl/exu_pkg.sv
hdl/exu_regfile.sv
hdl/exu_dispatch.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_lsu.sv
hdl/exu_writeback.sv
hdl/exu_top.sv
bench/exu_checker.sv
bench/exu_tb.sv

//--- Bender.yml
package:
  name: exu_stage

sources:
  - hdl/exu_pkg.sv
  - hdl/exu_regfile.sv
  - hdl/exu_dispatch.sv
  - hdl/exu_alu.sv
  - hdl/exu_bru.sv
  - hdl/exu_lsu.sv
  - hdl/exu_writeback.sv
  - hdl/exu_top.sv
  - target: simulation
    files:
      - bench/exu_checker.sv
      - bench/exu_tb.sv

//--- bench/exu_tb.sv
module exu_tb;
  import exu_pkg::*;

  localparam int PERIOD         = 100;
  localparam int RESET_CYCLES   = 16;
  localparam int CYCLES_PER_ROW = 40;
  localparam int MEM_WORDS      = 16;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  idu_req;
  logic                  idu_ack;
  logic [XLEN-1:0]       idu_inst;
  logic [XLEN-1:0]       idu_pc;
  logic                  bus_req;
  logic                  bus_write;
  logic                  bus_ack;
  logic [XLEN-1:0]       bus_addr;
  logic [XLEN-1:0]       bus_wdata;
  logic [BYTE_LANES-1:0] bus_mask;
  logic [XLEN-1:0]       bus_rdata;
  logic                  exu_vld;
  logic                  exu_rd_wr;
  logic                  exu_br_taken;
  logic                  exu_trap;
  logic [REG_ADDR_W-1:0] exu_rd;
  logic [XLEN-1:0]       exu_rd_data;
  logic [XLEN-1:0]       exu_pc;
  logic [XLEN-1:0]       exu_pc_next;

  // stimulus table with the expected retire report of each row.
  logic [XLEN-1:0]       inst_q[$];
  logic [XLEN-1:0]       pc_q[$];
  logic                  wr_q[$];
  logic [REG_ADDR_W-1:0] rd_q[$];
  logic [XLEN-1:0]       data_q[$];
  logic [XLEN-1:0]       next_q[$];
  logic                  taken_q[$];
  logic                  trap_q[$];

  logic [XLEN-1:0]       row_pc;
  logic [XLEN-1:0]       mem [0:MEM_WORDS-1];
  integer                seed = 32'habf460cb;
  int                    delay;
  int                    idx;
  int                    cur_row = 0;
  logic                  rows_ready = 1'b0;

  exu_top exu_top_inst (.*);

  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [XLEN-1:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [XLEN-1:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [XLEN-1:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [XLEN-1:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // rows get consecutive pcs, and pc_next is the target only when taken.
  task automatic add_row(input logic [XLEN-1:0] inst, input logic wr,
      input logic [REG_ADDR_W-1:0] rd, input logic [XLEN-1:0] data, input logic taken,
      input logic [XLEN-1:0] target, input logic trap);
    inst_q.push_back(inst);
    pc_q.push_back(row_pc);
    wr_q.push_back(wr);
    rd_q.push_back(rd);
    data_q.push_back(data);
    next_q.push_back(taken ? target : row_pc + 32'd4);
    taken_q.push_back(taken);
    trap_q.push_back(trap);
    row_pc = row_pc + 32'd4;
  endtask

  task automatic fill_table();
    row_pc = 32'h0000_0100;
    add_row(i_type(12'h123, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM), 1, 5'd1, 32'h0000_0123, 0, 0, 0);
    add_row(i_type(12'hffb, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM), 1, 5'd2, 32'hffff_fffb, 0, 0, 0);
    add_row(u_type(20'h80000, 5'd3, OPC_LUI), 1, 5'd3, 32'h8000_0000, 0, 0, 0);
    add_row(u_type(20'h00012, 5'd4, OPC_AUIPC), 1, 5'd4, 32'h0001_210c, 0, 0, 0);
    add_row(r_type(7'd0, 5'd2, 5'd1, F3_ADD, 5'd5), 1, 5'd5, 32'h0000_011e, 0, 0, 0);
    add_row(r_type(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd6), 1, 5'd6, 32'h0000_0128, 0, 0, 0);
    add_row(r_type(7'd0, 5'd1, 5'd1, F3_SLL, 5'd7), 1, 5'd7, 32'h0000_0918, 0, 0, 0);
    add_row(r_type(7'd0, 5'd1, 5'd3, F3_SR, 5'd8), 1, 5'd8, 32'h1000_0000, 0, 0, 0);
    add_row(r_type(F7_ALT, 5'd1, 5'd3, F3_SR, 5'd9), 1, 5'd9, 32'hf000_0000, 0, 0, 0);
    add_row(r_type(7'd0, 5'd1, 5'd2, F3_SLT, 5'd10), 1, 5'd10, 32'h0000_0001, 0, 0, 0);
    add_row(r_type(7'd0, 5'd1, 5'd2, F3_SLTU, 5'd11), 1, 5'd11, 32'h0000_0000, 0, 0, 0);
    add_row(r_type(7'd0, 5'd2, 5'd1, F3_XOR, 5'd12), 1, 5'd12, 32'hffff_fed8, 0, 0, 0);
    add_row(r_type(7'd0, 5'd4, 5'd1, F3_OR, 5'd13), 1, 5'd13, 32'h0001_212f, 0, 0, 0);
    add_row(r_type(7'd0, 5'd2, 5'd1, F3_AND, 5'd14), 1, 5'd14, 32'h0000_0123, 0, 0, 0);
    // x0 must still read as zero after this write.
    add_row(i_type(12'h055, 5'd0, F3_ADD, 5'd0, OPC_OP_IMM), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(r_type(7'd0, 5'd1, 5'd0, F3_ADD, 5'd15), 1, 5'd15, 32'h0000_0123, 0, 0, 0);
    add_row(b_type(13'h0010, 5'd14, 5'd1, F3_BEQ), 0, 5'd0, 32'h0, 1, 32'h0000_0150, 0);
    add_row(b_type(13'h0008, 5'd14, 5'd1, F3_BNE), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(b_type(13'h1ff8, 5'd1, 5'd2, F3_BLT), 0, 5'd0, 32'h0, 1, 32'h0000_0140, 0);
    add_row(b_type(13'h0020, 5'd1, 5'd2, F3_BGEU), 0, 5'd0, 32'h0, 1, 32'h0000_016c, 0);
    add_row(b_type(13'h000c, 5'd2, 5'd1, F3_BLT), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(b_type(13'h000c, 5'd2, 5'd1, F3_BGEU), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(j_type(21'h000100, 5'd16), 1, 5'd16, 32'h0000_015c, 1, 32'h0000_0258, 0);
    add_row(i_type(12'h010, 5'd1, 3'b000, 5'd17, OPC_JALR), 1, 5'd17, 32'h0000_0160, 1,
      32'h0000_0132, 0);
    // word 4 gets 0xfffffed8, word 5 gets 0x0123 low and 0xfb in byte 3.
    add_row(s_type(12'h010, 5'd12, 5'd0, F3_SW), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(s_type(12'h014, 5'd1, 5'd0, F3_SH), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(s_type(12'h017, 5'd2, 5'd0, F3_SB), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(i_type(12'h010, 5'd0, F3_LW, 5'd18, OPC_LOAD), 1, 5'd18, 32'hffff_fed8, 0, 0, 0);
    add_row(i_type(12'h010, 5'd0, F3_LH, 5'd19, OPC_LOAD), 1, 5'd19, 32'hffff_fed8, 0, 0, 0);
    add_row(i_type(12'h010, 5'd0, F3_LHU, 5'd20, OPC_LOAD), 1, 5'd20, 32'h0000_fed8, 0, 0, 0);
    add_row(i_type(12'h014, 5'd0, F3_LH, 5'd26, OPC_LOAD), 1, 5'd26, 32'h0000_0123, 0, 0, 0);
    add_row(i_type(12'h017, 5'd0, F3_LB, 5'd21, OPC_LOAD), 1, 5'd21, 32'hffff_fffb, 0, 0, 0);
    add_row(i_type(12'h017, 5'd0, F3_LBU, 5'd22, OPC_LOAD), 1, 5'd22, 32'h0000_00fb, 0, 0, 0);
    add_row(i_type(12'h011, 5'd0, F3_LBU, 5'd24, OPC_LOAD), 1, 5'd24, 32'h0000_00fe, 0, 0, 0);
    add_row(32'h0000_0073, 0, 5'd0, 32'h0, 0, 0, 1);
    add_row(r_type(7'd0, 5'd0, 5'd18, F3_ADD, 5'd25), 1, 5'd25, 32'hffff_fed8, 0, 0, 0);
    add_row(b_type(13'h0010, 5'd2, 5'd1, F3_BEQ), 0, 5'd0, 32'h0, 0, 0, 0);
    add_row(b_type(13'h0010, 5'd2, 5'd1, F3_BNE), 0, 5'd0, 32'h0, 1, 32'h0000_01a4, 0);
  endtask

  task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
      input string what);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: row %0d %s is %h, expected %h",
        $time, cur_row, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: row %0d %s is %b, expected %b",
        $time, cur_row, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic check_rd(input logic [REG_ADDR_W-1:0] got, input logic [REG_ADDR_W-1:0] exp);
    if (got !== exp)
    begin
      $display("ERROR at time %0t: row %0d exu_rd is %0d, expected %0d",
        $time, cur_row, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // called on a falling edge; returns one cycle after retirement so busy is clear.
  task automatic issue_row(input int n);
    logic [XLEN-1:0] cycles;
    logic            seen;
    cycles   = '0;
    seen     = 1'b0;
    cur_row  = n;
    idu_inst = inst_q[n];
    idu_pc   = pc_q[n];
    idu_req  = 1'b1;
    while (!seen)
    begin
      @(negedge clk);
      cycles = cycles + 1;
      if (idu_req && idu_ack)
      begin
        idu_req = 1'b0;
      end
      seen = exu_vld;
    end
    check_flag(exu_rd_wr, wr_q[n], "exu_rd_wr");
    check_rd(exu_rd, rd_q[n]);
    check_word(exu_rd_data, data_q[n], "exu_rd_data");
    check_word(exu_pc, pc_q[n], "exu_pc");
    check_word(exu_pc_next, next_q[n], "exu_pc_next");
    check_flag(exu_br_taken, taken_q[n], "exu_br_taken");
    check_flag(exu_trap, trap_q[n], "exu_trap");
    // single-cycle units retire on the third falling edge after req rises.
    if (inst_q[n][6:0] != OPC_LOAD && inst_q[n][6:0] != OPC_STORE)
    begin
      check_word(cycles, 32'd3, "retire latency in cycles");
    end
    @(negedge clk);
  endtask

  // memory responder on the data bus with a random 0 to 3 cycle delay.
  always
  begin
    @(negedge clk);
    if (bus_req && !bus_ack)
    begin
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(negedge clk);
      idx = bus_addr[5:2];
      if (bus_write)
      begin
        for (int b = 0; b < BYTE_LANES; b++)
        begin
          if (bus_mask[b])
          begin
            mem[idx][8*b +: 8] = bus_wdata[8*b +: 8];
          end
        end
      end
      else
      begin
        bus_rdata = mem[idx];
      end
      bus_ack = 1'b1;
      while (bus_req)
      begin
        @(negedge clk);
      end
      bus_ack = 1'b0;
    end
  end

  initial
  begin
    wait (rows_ready);
    #((RESET_CYCLES + 2 + CYCLES_PER_ROW * inst_q.size()) * PERIOD);
    $display("Timeout: the execute stage did not retire every row in time.");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    rst       = 1'b1;
    idu_req   = 1'b0;
    idu_inst  = '0;
    idu_pc    = '0;
    bus_ack   = 1'b0;
    bus_rdata = '0;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = 32'h5a5a_0000 ^ (i * 32'h0101_0101);
    end
    fill_table();
    rows_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    for (int i = 0; i < inst_q.size(); i++)
    begin
      issue_row(i);
    end
    if (exu_top_inst.exu_checker_inst.fails == 0)
    begin
      $display("Simulation completed successfully");
      $finish;
    end
    else
    begin
      $display("A handshake assertion failed during the run.");
      $display("Simulation failed");
      $fatal(1, "assertion failures were reported");
    end
  end

endmodule

//--- bench/exu_checker.sv
module exu_checker (
  input logic                            clk,
  input logic                            rst,
  input logic                            idu_req,
  input logic                            idu_ack,
  input logic                            bus_req,
  input logic                            bus_ack,
  input logic                            bus_write,
  input logic [exu_pkg::XLEN-1:0]        bus_addr,
  input logic [exu_pkg::XLEN-1:0]        bus_wdata,
  input logic [exu_pkg::BYTE_LANES-1:0]  bus_mask,
  input logic                            exu_vld
);

  // number of assertion failures so far.
  int fails = 0;

  // a bus request is held until the responder acknowledges it.
  req_held: assert property (@(posedge clk) disable iff (rst)
    bus_req && !bus_ack |=> bus_req)
    else
    begin
      $error("bus_req dropped before bus_ack was seen");
      fails++;
    end

  fields_stable: assert property (@(posedge clk) disable iff (rst)
    bus_req && !bus_ack |=> $stable({bus_write, bus_addr, bus_wdata, bus_mask}))
    else
    begin
      $error("bus fields changed while bus_req waited for bus_ack");
      fails++;
    end

  // ack is a reply, so the request must have been there when it was captured.
  ack_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(idu_ack) |-> $past(idu_req))
    else
    begin
      $error("idu_ack rose without idu_req");
      fails++;
    end

  vld_pulse: assert property (@(posedge clk) disable iff (rst)
    exu_vld |=> !exu_vld)
    else
    begin
      $error("exu_vld stayed high for more than one cycle");
      fails++;
    end

endmodule

bind exu_top exu_checker exu_checker_inst (
  .clk       (clk),
  .rst       (rst),
  .idu_req   (idu_req),
  .idu_ack   (idu_ack),
  .bus_req   (bus_req),
  .bus_ack   (bus_ack),
  .bus_write (bus_write),
  .bus_addr  (bus_addr),
  .bus_wdata (bus_wdata),
  .bus_mask  (bus_mask),
  .exu_vld   (exu_vld)
);

//--- hdl/exu_top.sv
module exu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            idu_req,
  output logic                            idu_ack,
  input  logic [exu_pkg::XLEN-1:0]        idu_inst,
  input  logic [exu_pkg::XLEN-1:0]        idu_pc,
  output logic                            bus_req,
  output logic                            bus_write,
  input  logic                            bus_ack,
  output logic [exu_pkg::XLEN-1:0]        bus_addr,
  output logic [exu_pkg::XLEN-1:0]        bus_wdata,
  output logic [exu_pkg::BYTE_LANES-1:0]  bus_mask,
  input  logic [exu_pkg::XLEN-1:0]        bus_rdata,
  output logic                            exu_vld,
  output logic                            exu_rd_wr,
  output logic                            exu_br_taken,
  output logic                            exu_trap,
  output logic [exu_pkg::REG_ADDR_W-1:0]  exu_rd,
  output logic [exu_pkg::XLEN-1:0]        exu_rd_data,
  output logic [exu_pkg::XLEN-1:0]        exu_pc,
  output logic [exu_pkg::XLEN-1:0]        exu_pc_next
);
  import exu_pkg::*;

  logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr, wr_addr;
  logic [XLEN-1:0]       rs1_data, rs2_data, wr_data;
  logic [XLEN-1:0]       op_inst, op_pc, op_rs1, op_rs2;
  logic [XLEN-1:0]       alu_result, bru_target, bru_link, lsu_result;
  logic                  alu_start, bru_start, lsu_start, trap_start;
  logic                  alu_done, bru_done, lsu_done;
  logic                  bru_taken, lsu_rd_wr, wr_en;

  exu_dispatch dispatch_inst (
    .clk, .rst, .idu_req, .idu_ack, .idu_inst, .idu_pc,
    .retire     (exu_vld),
    .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .alu_start, .bru_start, .lsu_start, .trap_start,
    .op_inst, .op_pc, .op_rs1, .op_rs2
  );

  exu_regfile regfile_inst (
    .clk, .rst, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .wr_en, .wr_addr, .wr_data
  );

  exu_alu alu_inst (
    .clk, .rst,
    .start  (alu_start),
    .inst   (op_inst),
    .pc     (op_pc),
    .rs1    (op_rs1),
    .rs2    (op_rs2),
    .done   (alu_done),
    .result (alu_result)
  );

  exu_bru bru_inst (
    .clk, .rst,
    .start  (bru_start),
    .inst   (op_inst),
    .pc     (op_pc),
    .rs1    (op_rs1),
    .rs2    (op_rs2),
    .done   (bru_done),
    .taken  (bru_taken),
    .target (bru_target),
    .link   (bru_link)
  );

  exu_lsu lsu_inst (
    .clk, .rst,
    .start  (lsu_start),
    .inst   (op_inst),
    .rs1    (op_rs1),
    .rs2    (op_rs2),
    .done   (lsu_done),
    .rd_wr  (lsu_rd_wr),
    .result (lsu_result),
    .bus_req, .bus_write, .bus_ack, .bus_addr, .bus_wdata, .bus_mask, .bus_rdata
  );

  exu_writeback writeback_inst (
    .clk, .rst,
    .alu_done, .bru_done, .lsu_done, .trap_start,
    .alu_result, .bru_link, .bru_target, .lsu_result,
    .bru_taken, .lsu_rd_wr,
    .inst   (op_inst),
    .pc     (op_pc),
    .wr_en, .wr_addr, .wr_data,
    .exu_vld, .exu_rd_wr, .exu_br_taken, .exu_trap,
    .exu_rd, .exu_rd_data, .exu_pc, .exu_pc_next
  );

endmodule

//--- hdl/exu_writeback.sv
module exu_writeback (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            alu_done,
  input  logic                            bru_done,
  input  logic                            lsu_done,
  input  logic                            trap_start,
  input  logic [exu_pkg::XLEN-1:0]        alu_result,
  input  logic [exu_pkg::XLEN-1:0]        bru_link,
  input  logic [exu_pkg::XLEN-1:0]        bru_target,
  input  logic [exu_pkg::XLEN-1:0]        lsu_result,
  input  logic                            bru_taken,
  input  logic                            lsu_rd_wr,
  input  logic [exu_pkg::XLEN-1:0]        inst,
  input  logic [exu_pkg::XLEN-1:0]        pc,
  output logic                            wr_en,
  output logic [exu_pkg::REG_ADDR_W-1:0]  wr_addr,
  output logic [exu_pkg::XLEN-1:0]        wr_data,
  output logic                            exu_vld,
  output logic                            exu_rd_wr,
  output logic                            exu_br_taken,
  output logic                            exu_trap,
  output logic [exu_pkg::REG_ADDR_W-1:0]  exu_rd,
  output logic [exu_pkg::XLEN-1:0]        exu_rd_data,
  output logic [exu_pkg::XLEN-1:0]        exu_pc,
  output logic [exu_pkg::XLEN-1:0]        exu_pc_next
);
  import exu_pkg::*;

  insn_u           v;
  logic            trap_q;
  logic            finish;
  logic            wr_ok;
  logic [XLEN-1:0] pc_nxt;

  assign v       = inst;
  assign wr_addr = v.r.rd;
  assign finish  = alu_done || bru_done || lsu_done || trap_q;

  always_comb
  begin
    wr_ok   = 1'b0;
    wr_data = alu_result;
    pc_nxt  = pc + 32'd4;
    if (alu_done)
    begin
      wr_ok = 1'b1;
    end
    else if (bru_done)
    begin
      // conditional branches have no rd.
      wr_ok   = (v.r.opcode != OPC_BRANCH);
      wr_data = bru_link;
      pc_nxt  = bru_target;
    end
    else if (lsu_done)
    begin
      wr_ok   = lsu_rd_wr;
      wr_data = lsu_result;
    end
  end

  assign wr_en = wr_ok && (wr_addr != '0);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      exu_vld <= 1'b0;
      trap_q  <= 1'b0;
    end
    else
    begin
      exu_vld <= finish;
      trap_q  <= trap_start;
    end
  end

  always_ff @(posedge clk)
  begin
    if (finish)
    begin
      exu_rd_wr    <= wr_en;
      exu_rd       <= wr_en ? wr_addr : '0;
      exu_rd_data  <= wr_en ? wr_data : '0;
      exu_br_taken <= bru_done && bru_taken;
      exu_trap     <= trap_q;
      exu_pc       <= pc;
      exu_pc_next  <= pc_nxt;
    end
  end

endmodule

//--- hdl/exu_lsu.sv
module exu_lsu (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            start,
  input  logic [exu_pkg::XLEN-1:0]        inst,
  input  logic [exu_pkg::XLEN-1:0]        rs1,
  input  logic [exu_pkg::XLEN-1:0]        rs2,
  output logic                            done,
  output logic                            rd_wr,
  output logic [exu_pkg::XLEN-1:0]        result,
  output logic                            bus_req,
  output logic                            bus_write,
  input  logic                            bus_ack,
  output logic [exu_pkg::XLEN-1:0]        bus_addr,
  output logic [exu_pkg::XLEN-1:0]        bus_wdata,
  output logic [exu_pkg::BYTE_LANES-1:0]  bus_mask,
  input  logic [exu_pkg::XLEN-1:0]        bus_rdata
);
  import exu_pkg::*;

  insn_u                 v;
  logic                  is_store;
  logic [XLEN-1:0]       addr;
  logic [1:0]            off;
  logic [BYTE_LANES-1:0] mask;
  logic [XLEN-1:0]       wdata;
  logic                  wait_low;
  logic [XLEN-1:0]       rdata_q;
  logic [XLEN-1:0]       lane;

  assign v        = inst;
  assign is_store = (v.s.opcode == OPC_STORE);
  assign addr     = is_store ? rs1 + {{(XLEN-12){v.s.imm_hi[6]}}, v.s.imm_hi, v.s.imm_lo}
                             : rs1 + {{(XLEN-12){v.i.imm[11]}}, v.i.imm};
  assign off      = addr[1:0];

  always_comb
  begin
    mask  = '0;
    wdata = rs2;
    if (is_store)
    begin
      case (v.s.funct3)
        F3_SB:
        begin
          mask  = 4'b0001 << off;
          wdata = {4{rs2[7:0]}};
        end
        F3_SH:
        begin
          mask  = 4'b0011 << {off[1], 1'b0};
          wdata = {2{rs2[15:0]}};
        end
        F3_SW:   mask = 4'b1111;
        default: mask = '0;
      endcase
    end
    else
    begin
      case (v.i.funct3)
        F3_LB, F3_LBU: mask = 4'b0001 << off;
        F3_LH, F3_LHU: mask = 4'b0011 << {off[1], 1'b0};
        F3_LW:         mask = 4'b1111;
        default:       mask = '0;
      endcase
    end
  end

  // req phase runs while bus_req is high, then wait_low covers the ack drop.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bus_req  <= 1'b0;
      wait_low <= 1'b0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        bus_req <= 1'b1;
      end
      else if (bus_req && bus_ack)
      begin
        bus_req  <= 1'b0;
        wait_low <= 1'b1;
      end
      else if (wait_low && !bus_ack)
      begin
        wait_low <= 1'b0;
        done     <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      bus_write <= is_store;
      bus_addr  <= addr;
      bus_wdata <= wdata;
      bus_mask  <= mask;
    end
    if (bus_req && bus_ack)
    begin
      rdata_q <= bus_rdata;
    end
  end

  assign lane  = rdata_q >> {bus_addr[1:0], 3'b000};
  assign rd_wr = (v.i.opcode == OPC_LOAD);

  always_comb
  begin
    case (v.i.funct3)
      F3_LB:   result = {{(XLEN-8){lane[7]}}, lane[7:0]};
      F3_LBU:  result = {{(XLEN-8){1'b0}}, lane[7:0]};
      F3_LH:   result = {{(XLEN-16){lane[15]}}, lane[15:0]};
      F3_LHU:  result = {{(XLEN-16){1'b0}}, lane[15:0]};
      default: result = lane;
    endcase
  end

endmodule

//--- hdl/exu_bru.sv
module exu_bru (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [exu_pkg::XLEN-1:0]  inst,
  input  logic [exu_pkg::XLEN-1:0]  pc,
  input  logic [exu_pkg::XLEN-1:0]  rs1,
  input  logic [exu_pkg::XLEN-1:0]  rs2,
  output logic                      done,
  output logic                      taken,
  output logic [exu_pkg::XLEN-1:0]  target,
  output logic [exu_pkg::XLEN-1:0]  link
);
  import exu_pkg::*;

  insn_u           v;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] jump_pc;
  logic [XLEN-1:0] seq_pc;
  logic            cond;
  logic            take;

  assign v      = inst;
  assign seq_pc = pc + 32'd4;
  assign imm_i  = {{(XLEN-12){v.i.imm[11]}}, v.i.imm};
  assign imm_b  = {{(XLEN-12){v.b.imm12}}, v.b.imm11, v.b.imm10_5, v.b.imm4_1, 1'b0};
  assign imm_j  = {{(XLEN-20){v.j.imm20}}, v.j.imm19_12, v.j.imm11, v.j.imm10_1, 1'b0};

  always_comb
  begin
    case (v.b.funct3)
      F3_BEQ:  cond = (rs1 == rs2);
      F3_BNE:  cond = (rs1 != rs2);
      F3_BLT:  cond = ($signed(rs1) < $signed(rs2));
      F3_BGE:  cond = ($signed(rs1) >= $signed(rs2));
      F3_BLTU: cond = (rs1 < rs2);
      F3_BGEU: cond = (rs1 >= rs2);
      default: cond = 1'b0;
    endcase
    case (v.r.opcode)
      OPC_JAL:  jump_pc = pc + imm_j;
      OPC_JALR: jump_pc = (rs1 + imm_i) & ~32'd1;
      default:  jump_pc = pc + imm_b;
    endcase
    take = (v.r.opcode == OPC_BRANCH) ? cond : 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= start;
    end
  end

  // target is the pc that actually follows, taken or not.
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      taken  <= take;
      target <= take ? jump_pc : seq_pc;
      link   <= seq_pc;
    end
  end

endmodule

//--- hdl/exu_alu.sv
module exu_alu (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [exu_pkg::XLEN-1:0]  inst,
  input  logic [exu_pkg::XLEN-1:0]  pc,
  input  logic [exu_pkg::XLEN-1:0]  rs1,
  input  logic [exu_pkg::XLEN-1:0]  rs2,
  output logic                      done,
  output logic [exu_pkg::XLEN-1:0]  result
);
  import exu_pkg::*;

  insn_u           v;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic            alt;
  logic [XLEN-1:0] res;

  assign v     = inst;
  assign imm_i = {{(XLEN-12){v.i.imm[11]}}, v.i.imm};
  assign op_b  = (v.r.opcode == OPC_OP) ? rs2 : imm_i;
  assign shamt = op_b[4:0];
  assign alt   = (v.r.funct7 == F7_ALT);

  always_comb
  begin
    case (v.r.opcode)
      OPC_LUI:   res = {v.u.imm, 12'b0};
      OPC_AUIPC: res = pc + {v.u.imm, 12'b0};
      default:
      begin
        case (v.r.funct3)
          // ADDI has no subtract form, so alt only counts for register ops.
          F3_ADD:  res = (alt && v.r.opcode == OPC_OP) ? rs1 - op_b : rs1 + op_b;
          F3_SLL:  res = rs1 << shamt;
          F3_SLT:  res = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(op_b)};
          F3_SLTU: res = {{(XLEN-1){1'b0}}, rs1 < op_b};
          F3_XOR:  res = rs1 ^ op_b;
          F3_SR:   res = alt ? $unsigned($signed(rs1) >>> shamt) : rs1 >> shamt;
          F3_OR:   res = rs1 | op_b;
          F3_AND:  res = rs1 & op_b;
          default: res = '0;
        endcase
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      done <= 1'b0;
    end
    else
    begin
      done <= start;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      result <= res;
    end
  end

endmodule

//--- hdl/exu_dispatch.sv
module exu_dispatch (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            idu_req,
  output logic                            idu_ack,
  input  logic [exu_pkg::XLEN-1:0]        idu_inst,
  input  logic [exu_pkg::XLEN-1:0]        idu_pc,
  input  logic                            retire,
  output logic [exu_pkg::REG_ADDR_W-1:0]  rs1_addr,
  output logic [exu_pkg::REG_ADDR_W-1:0]  rs2_addr,
  input  logic [exu_pkg::XLEN-1:0]        rs1_data,
  input  logic [exu_pkg::XLEN-1:0]        rs2_data,
  output logic                            alu_start,
  output logic                            bru_start,
  output logic                            lsu_start,
  output logic                            trap_start,
  output logic [exu_pkg::XLEN-1:0]        op_inst,
  output logic [exu_pkg::XLEN-1:0]        op_pc,
  output logic [exu_pkg::XLEN-1:0]        op_rs1,
  output logic [exu_pkg::XLEN-1:0]        op_rs2
);
  import exu_pkg::*;

  insn_u v;
  logic  busy;
  logic  capture;
  logic  to_alu;
  logic  to_bru;
  logic  to_lsu;

  assign v        = idu_inst;
  assign rs1_addr = v.r.rs1;
  assign rs2_addr = v.r.rs2;

  // a new word is taken only when nothing is in flight.
  assign capture = idu_req && !idu_ack && !busy;

  always_comb
  begin
    to_alu = 1'b0;
    to_bru = 1'b0;
    to_lsu = 1'b0;
    case (v.r.opcode)
      OPC_LUI, OPC_AUIPC, OPC_OP_IMM, OPC_OP: to_alu = 1'b1;
      OPC_JAL, OPC_JALR, OPC_BRANCH:          to_bru = 1'b1;
      OPC_LOAD, OPC_STORE:                    to_lsu = 1'b1;
      default:                                ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idu_ack    <= 1'b0;
      busy       <= 1'b0;
      alu_start  <= 1'b0;
      bru_start  <= 1'b0;
      lsu_start  <= 1'b0;
      trap_start <= 1'b0;
    end
    else
    begin
      alu_start  <= capture && to_alu;
      bru_start  <= capture && to_bru;
      lsu_start  <= capture && to_lsu;
      trap_start <= capture && !(to_alu || to_bru || to_lsu);
      if (capture)
      begin
        idu_ack <= 1'b1;
        busy    <= 1'b1;
      end
      else
      begin
        if (idu_ack && !idu_req)
        begin
          idu_ack <= 1'b0;
        end
        if (retire)
        begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      op_inst <= idu_inst;
      op_pc   <= idu_pc;
      op_rs1  <= rs1_data;
      op_rs2  <= rs2_data;
    end
  end

endmodule

//--- hdl/exu_regfile.sv
module exu_regfile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [exu_pkg::REG_ADDR_W-1:0]  rs1_addr,
  input  logic [exu_pkg::REG_ADDR_W-1:0]  rs2_addr,
  output logic [exu_pkg::XLEN-1:0]        rs1_data,
  output logic [exu_pkg::XLEN-1:0]        rs2_data,
  input  logic                            wr_en,
  input  logic [exu_pkg::REG_ADDR_W-1:0]  wr_addr,
  input  logic [exu_pkg::XLEN-1:0]        wr_data
);
  import exu_pkg::*;

  // x0 has no storage behind it.
  logic [XLEN-1:0] regs [1:NUM_REGS-1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int n = 1; n < NUM_REGS; n++)
      begin
        regs[n] <= '0;
      end
    end
    else if (wr_en && wr_addr != '0)
    begin
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/exu_pkg.sv
package exu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  localparam int BYTE_LANES = 4;

  // major opcodes of the supported RV32I subset.
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // funct7 value that selects SUB and SRA/SRAI.
  localparam logic [6:0] F7_ALT = 7'b0100000;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_LB  = 3'b000;
  localparam logic [2:0] F3_LH  = 3'b001;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_LBU = 3'b100;
  localparam logic [2:0] F3_LHU = 3'b101;
  localparam logic [2:0] F3_SB  = 3'b000;
  localparam logic [2:0] F3_SH  = 3'b001;
  localparam logic [2:0] F3_SW  = 3'b010;

  // one instruction word seen through each base encoding format.
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } insn_u;

endpackage
